//--- source/ide_pkg.sv
// Shared types and constants for the IDE task-file bridge
// Address word is decoded as CHS or LBA28 depending on the LBA bit of device/head
// Only READ SECTOR(S) and WRITE SECTOR(S) are recognised, everything else aborts
package ide_pkg;

	typedef enum logic [2:0] {
		reg_data       = 3'd0,
		reg_error      = 3'd1,
		reg_count      = 3'd2,
		reg_sector     = 3'd3,
		reg_cyl_low    = 3'd4,
		reg_cyl_high   = 3'd5,
		reg_dev_head   = 3'd6,
		reg_cmd_status = 3'd7
	} reg_addr_e;

	localparam logic [7:0] cmd_read = 8'h20;
	localparam logic [7:0] cmd_read_retry = 8'h21;
	localparam logic [7:0] cmd_write = 8'h30;
	localparam logic [7:0] cmd_write_retry = 8'h31;

	localparam logic [7:0] err_abrt = 8'h04;
	localparam logic [7:0] err_unc = 8'h40;

	localparam int sector_bytes = 512;

	typedef struct packed {
		logic bsy;
		logic drdy;
		logic [1:0] rsvd_hi; // DF and DSC, always zero
		logic drq;
		logic [1:0] rsvd_lo; // CORR and IDX, always zero
		logic err;
	} status_t;

	typedef struct packed {
		logic wr_cmd;
		logic wr_ctl;
		logic rd_cmd;
		reg_addr_e addr;
		logic [15:0] data;
	} host_access_t;

	typedef union packed {
		struct packed {
			logic [3:0] head;
			logic [15:0] cylinder;
			logic [7:0] sector;
		} chs;
		logic [27:0] lba;
	} task_addr_u;

	typedef struct packed {
		logic [27:0] lba;
		logic write;
	} blk_cmd_t;

	typedef struct packed {
		logic valid;
		logic [7:0] data;
	} blk_byte_t;

endpackage

//--- source/ide_bus_sync.sv
// Host strobes and chip selects are sampled directly on the clock
// Host must keep chip select, address and data stable while a strobe is low
// Write event one cycle after write_n rises, read event one cycle after read_n falls
`timescale 1ns/1ns

module ide_bus_sync (
	input logic clock,
	input logic reset,
	input logic cs_cmd_n,
	input logic cs_ctl_n,
	input logic read_n,
	input logic write_n,
	input logic [2:0] address,
	input logic [15:0] data_in,
	output ide_pkg::host_access_t access
);

	logic prev_read_n;
	logic prev_write_n;
	logic cs_cmd_q;
	logic cs_ctl_q;
	logic wr_cmd_q;
	logic wr_ctl_q;
	logic rd_cmd_q;
	logic [2:0] addr_q;
	logic [15:0] data_q;
	logic [2:0] event_addr;
	logic [15:0] event_data;
	logic read_fall;
	logic write_rise;

	assign read_fall = prev_read_n && !read_n;
	assign write_rise = !prev_write_n && write_n;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			prev_read_n <= 1'b1;
			prev_write_n <= 1'b1;
			cs_cmd_q <= 1'b0;
			cs_ctl_q <= 1'b0;
			wr_cmd_q <= 1'b0;
			wr_ctl_q <= 1'b0;
			rd_cmd_q <= 1'b0;
		end else begin
			prev_read_n <= read_n;
			prev_write_n <= write_n;
			cs_cmd_q <= !cs_cmd_n;
			cs_ctl_q <= !cs_ctl_n;
			wr_cmd_q <= write_rise && cs_cmd_q; // Select seen while strobe was low
			wr_ctl_q <= write_rise && cs_ctl_q;
			rd_cmd_q <= read_fall && !cs_cmd_n;
		end
	end

	always_ff @(posedge clock) begin
		if (!cs_cmd_n || !cs_ctl_n) begin
			addr_q <= address;
			data_q <= data_in;
		end
		event_addr <= read_fall ? address : addr_q;
		event_data <= data_q;
	end

	assign access = '{
		wr_cmd: wr_cmd_q,
		wr_ctl: wr_ctl_q,
		rd_cmd: rd_cmd_q,
		addr: ide_pkg::reg_addr_e'(event_addr),
		data: event_data
	};

endmodule

//--- source/ide_task_file.sv
// Task-file registers and host readback
// Defaults after reset or software reset: count 1, sector 1, all else 0
// The drive bit is stored and read back only, never compared
// Control block reads are not decoded, only command block reads update data_out
`timescale 1ns/1ns

module ide_task_file (
	input logic clock,
	input logic reset,
	input ide_pkg::host_access_t access,
	input ide_pkg::status_t status,
	input logic [7:0] error,
	input logic [15:0] buf_word,
	input logic load_error,
	output ide_pkg::task_addr_u task_addr,
	output logic use_lba,
	output logic [7:0] sector_count,
	output logic [15:0] data_out,
	output logic soft_reset
);

	logic [7:0] sector_q;
	logic [7:0] cyl_low_q;
	logic [7:0] cyl_high_q;
	logic [3:0] head_q;
	logic drive_q;
	logic [7:0] error_q;

	// SRST bit of device control
	assign soft_reset = access.wr_ctl && access.addr == ide_pkg::reg_dev_head && access.data[2];

	always_comb begin
		task_addr.chs.head = head_q;
		task_addr.chs.cylinder = {cyl_high_q, cyl_low_q};
		task_addr.chs.sector = sector_q;
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			sector_count <= 8'd1;
			sector_q <= 8'd1;
			cyl_low_q <= 8'd0;
			cyl_high_q <= 8'd0;
			head_q <= 4'd0;
			drive_q <= 1'b0;
			use_lba <= 1'b0;
			error_q <= 8'd0;
		end else if (soft_reset) begin
			sector_count <= 8'd1;
			sector_q <= 8'd1;
			cyl_low_q <= 8'd0;
			cyl_high_q <= 8'd0;
			head_q <= 4'd0;
			drive_q <= 1'b0;
			use_lba <= 1'b0;
			error_q <= 8'd0;
		end else begin
			if (load_error)
				error_q <= error;
			if (access.wr_cmd) begin
				case (access.addr)
					ide_pkg::reg_count: sector_count <= access.data[7:0];
					ide_pkg::reg_sector: sector_q <= access.data[7:0];
					ide_pkg::reg_cyl_low: cyl_low_q <= access.data[7:0];
					ide_pkg::reg_cyl_high: cyl_high_q <= access.data[7:0];
					ide_pkg::reg_dev_head: begin
						head_q <= access.data[3:0];
						drive_q <= access.data[4];
						use_lba <= access.data[6];
					end
					default: ; // Data and command go to the controller
				endcase
			end
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			data_out <= 16'h0000;
		else if (access.rd_cmd) begin
			case (access.addr)
				ide_pkg::reg_data: data_out <= buf_word;
				ide_pkg::reg_error: data_out <= {8'h00, error_q};
				ide_pkg::reg_count: data_out <= {8'h00, sector_count};
				ide_pkg::reg_sector: data_out <= {8'h00, sector_q};
				ide_pkg::reg_cyl_low: data_out <= {8'h00, cyl_low_q};
				ide_pkg::reg_cyl_high: data_out <= {8'h00, cyl_high_q};
				ide_pkg::reg_dev_head: data_out <= {8'h00, 1'b1, use_lba, 1'b1, drive_q, head_q};
				ide_pkg::reg_cmd_status: data_out <= {8'h00, status};
			endcase
		end
	end

endmodule

//--- source/chs_to_lba.sv
// CHS to LBA by repeated addition, one add per clock
// Latency about num_heads + sectors_per_track cycles
// Sector number 0 is not a valid CHS sector and wraps the result
// Result and done hold while start stays high
`timescale 1ns/1ns

module chs_to_lba #(
	parameter int num_heads = 16,
	parameter int sectors_per_track = 63
) (
	input logic clock,
	input logic reset,
	input logic start,
	input ide_pkg::task_addr_u chs,
	output logic [27:0] lba,
	output logic done
);

	typedef enum logic [1:0] {s_idle, s_heads, s_sectors, s_done} state_e;

	state_e state;
	logic [7:0] count;
	logic [27:0] track; // cylinder * heads + head

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= s_idle;
			count <= 8'd0;
			track <= 28'd0;
			lba <= 28'd0;
		end else if (!start)
			state <= s_idle;
		else begin
			case (state)
				s_idle: begin
					track <= 28'(chs.chs.head);
					count <= 8'(num_heads);
					state <= s_heads;
				end
				s_heads:
					if (count == 8'd0) begin
						lba <= 28'(chs.chs.sector) - 28'd1;
						count <= 8'(sectors_per_track);
						state <= s_sectors;
					end else begin
						track <= track + 28'(chs.chs.cylinder);
						count <= count - 8'd1;
					end
				s_sectors:
					if (count == 8'd0)
						state <= s_done;
					else begin
						lba <= lba + track;
						count <= count - 8'd1;
					end
				s_done: ; // Hold until start drops
			endcase
		end
	end

	assign done = state == s_done;

endmodule

//--- source/sector_buffer.sv
// One-sector byte FIFO, 512 bytes
// Push when full and pop when empty are ignored
// head_word is the next two bytes, first byte in the low half
`timescale 1ns/1ns

module sector_buffer (
	input logic clock,
	input logic reset,
	input logic clear,
	input logic push,
	input logic [7:0] push_byte,
	input logic pop,
	output logic [15:0] head_word,
	output logic empty,
	output logic full
);

	localparam int addr_w = $clog2(ide_pkg::sector_bytes);

	logic [7:0] mem [ide_pkg::sector_bytes];
	logic [addr_w:0] wr_ptr; // Extra bit tells full from empty
	logic [addr_w:0] rd_ptr;
	logic [addr_w-1:0] rd_next;

	always_ff @(posedge clock) begin
		if (push && !full)
			mem[wr_ptr[addr_w-1:0]] <= push_byte;
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push && !full)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop && !empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	assign rd_next = rd_ptr[addr_w-1:0] + 1'b1;
	assign head_word = {mem[rd_next], mem[rd_ptr[addr_w-1:0]]};
	assign empty = wr_ptr == rd_ptr;
	assign full = wr_ptr == {~rd_ptr[addr_w], rd_ptr[addr_w-1:0]};

endmodule

//--- source/ide_command_ctrl.sv
// Command FSM for READ/WRITE SECTOR(S), everything else aborts with ABRT
// Storage channels are credit based: 1 command credit and 0 write credits after reset
// Read credits are granted only after the command is sent, at most read_credits open
// Storage drops any unused read credits when it pulses sector_done
// Write credits beyond 1023 outstanding are not supported
// Host word transfers move two buffer bytes on consecutive cycles, low byte first
`timescale 1ns/1ns

module ide_command_ctrl #(
	parameter int read_credits = 8
) (
	input logic clock,
	input logic reset,
	input ide_pkg::host_access_t access,
	input logic soft_reset,
	input logic use_lba,
	input ide_pkg::task_addr_u task_addr,
	input logic [7:0] sector_count,
	input logic lba_done,
	input logic [27:0] lba,
	input logic buf_empty,
	input logic buf_full,
	input logic [7:0] buf_head,
	input logic cmd_credit,
	input logic wr_credit,
	input ide_pkg::blk_byte_t rd_byte,
	input logic sector_done,
	input logic sector_error,
	output ide_pkg::status_t status,
	output logic [7:0] error,
	output logic load_error,
	output logic lba_start,
	output logic buf_clear,
	output logic buf_push,
	output logic [7:0] buf_push_byte,
	output logic buf_pop,
	output logic cmd_valid,
	output ide_pkg::blk_cmd_t cmd,
	output ide_pkg::blk_byte_t wr_byte,
	output logic rd_credit
);

	typedef enum logic [3:0] {
		s_boot, s_idle, s_resolve, s_sector, s_host_wr,
		s_send_cmd, s_fill, s_host_rd, s_drain, s_next
	} state_e;

	localparam int rd_cnt_w = $clog2(read_credits + 1);

	state_e state;
	logic write_op;
	logic err_flag;
	logic odd_byte; // Second byte of a host word pending
	logic [7:0] high_byte;
	logic [8:0] remaining;
	logic [27:0] lba_q;
	logic [1:0] cmd_credits;
	logic [9:0] wr_credits;
	logic [rd_cnt_w-1:0] rd_outstanding;
	logic [9:0] rd_granted;
	logic [7:0] opcode;
	logic is_read;
	logic is_write;
	logic cmd_event;
	logic data_wr;
	logic data_rd;
	logic send_cmd;
	logic send_byte;
	logic grant;

	assign opcode = access.data[7:0];
	assign is_read = opcode == ide_pkg::cmd_read || opcode == ide_pkg::cmd_read_retry;
	assign is_write = opcode == ide_pkg::cmd_write || opcode == ide_pkg::cmd_write_retry;
	assign cmd_event = access.wr_cmd && access.addr == ide_pkg::reg_cmd_status;
	assign data_wr = access.wr_cmd && access.addr == ide_pkg::reg_data;
	assign data_rd = access.rd_cmd && access.addr == ide_pkg::reg_data;

	assign send_cmd = state == s_send_cmd && cmd_credits != 2'd0;
	assign send_byte = state == s_drain && wr_credits != 10'd0 && !buf_empty;
	assign grant = state == s_fill && !sector_done &&
		rd_granted != 10'(ide_pkg::sector_bytes) && rd_outstanding != rd_cnt_w'(read_credits);

	assign cmd_valid = send_cmd;
	assign cmd = '{lba: lba_q, write: write_op};
	assign wr_byte = '{valid: send_byte, data: buf_head};
	assign rd_credit = grant;

	assign lba_start = state == s_resolve && !use_lba;
	assign buf_clear = state == s_sector;
	assign buf_push = (state == s_fill && rd_byte.valid) ||
		(state == s_host_wr && (data_wr || odd_byte));
	assign buf_push_byte = state == s_fill ? rd_byte.data : (odd_byte ? high_byte : opcode);
	assign buf_pop = send_byte || (state == s_host_rd && (data_rd || odd_byte));

	assign status.bsy = !(state inside {s_idle, s_host_wr, s_host_rd});
	assign status.drdy = state != s_boot;
	assign status.rsvd_hi = 2'b00;
	assign status.drq = state inside {s_host_wr, s_host_rd};
	assign status.rsvd_lo = 2'b00;
	assign status.err = err_flag;

	always_ff @(posedge clock) begin
		if (data_wr)
			high_byte <= access.data[15:8];
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= s_boot;
			write_op <= 1'b0;
			err_flag <= 1'b0;
			odd_byte <= 1'b0;
			error <= 8'h00;
			load_error <= 1'b0;
			remaining <= 9'd0;
			lba_q <= 28'd0;
		end else if (soft_reset) begin
			state <= s_boot;
			err_flag <= 1'b0;
			odd_byte <= 1'b0;
			load_error <= 1'b0;
		end else begin
			load_error <= 1'b0;
			odd_byte <= 1'b0;
			case (state)
				s_boot: state <= s_idle;
				s_idle:
					if (cmd_event) begin
						err_flag <= !(is_read || is_write);
						error <= (is_read || is_write) ? 8'h00 : ide_pkg::err_abrt;
						load_error <= 1'b1;
						write_op <= is_write;
						remaining <= {sector_count == 8'd0, sector_count}; // 0 means 256
						if (is_read || is_write)
							state <= s_resolve;
					end
				s_resolve:
					if (use_lba) begin
						lba_q <= task_addr.lba;
						state <= s_sector;
					end else if (lba_done) begin
						lba_q <= lba;
						state <= s_sector;
					end
				s_sector: state <= write_op ? s_host_wr : s_send_cmd;
				s_host_wr:
					if (data_wr)
						odd_byte <= 1'b1;
					else if (buf_full && !odd_byte)
						state <= s_send_cmd;
				s_send_cmd:
					if (send_cmd)
						state <= write_op ? s_drain : s_fill;
				s_fill, s_drain:
					if (sector_done && sector_error) begin
						err_flag <= 1'b1;
						error <= ide_pkg::err_unc;
						load_error <= 1'b1;
						state <= s_idle;
					end else if (sector_done)
						state <= write_op ? s_next : s_host_rd;
				s_host_rd:
					if (data_rd)
						odd_byte <= 1'b1;
					else if (buf_empty && !odd_byte)
						state <= s_next;
				s_next: begin
					remaining <= remaining - 9'd1;
					lba_q <= lba_q + 28'd1;
					state <= remaining == 9'd1 ? s_idle : s_sector;
				end
				default: state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			cmd_credits <= 2'd1;
			wr_credits <= 10'd0;
			rd_outstanding <= '0;
			rd_granted <= 10'd0;
		end else begin
			cmd_credits <= cmd_credits + 2'(cmd_credit) - 2'(send_cmd);
			wr_credits <= wr_credits + 10'(wr_credit) - 10'(send_byte);
			if (sector_done)
				rd_outstanding <= '0; // Unused grants lapse
			else
				rd_outstanding <= rd_outstanding + rd_cnt_w'(grant) - rd_cnt_w'(rd_byte.valid);
			if (state == s_sector)
				rd_granted <= 10'd0;
			else if (grant)
				rd_granted <= rd_granted + 10'd1;
		end
	end

endmodule

//--- source/ide_block_bridge.sv
// IDE PIO task-file front end to a credit-based block port
// Geometry for CHS translation is fixed by num_heads and sectors_per_track
// read_credits bounds the read bytes granted to storage but not yet received
`timescale 1ns/1ns

module ide_block_bridge #(
	parameter int num_heads = 16,
	parameter int sectors_per_track = 63,
	parameter int read_credits = 8
) (
	input logic clock,
	input logic reset,
	input logic cs_cmd_n,
	input logic cs_ctl_n,
	input logic read_n,
	input logic write_n,
	input logic [2:0] address,
	input logic [15:0] data_in,
	output logic [15:0] data_out,
	input logic cmd_credit,
	input logic wr_credit,
	input ide_pkg::blk_byte_t rd_byte,
	input logic sector_done,
	input logic sector_error,
	output logic cmd_valid,
	output ide_pkg::blk_cmd_t cmd,
	output ide_pkg::blk_byte_t wr_byte,
	output logic rd_credit
);

	ide_pkg::host_access_t access;
	ide_pkg::status_t status;
	ide_pkg::task_addr_u task_addr;
	logic [7:0] error;
	logic load_error;
	logic use_lba;
	logic [7:0] sector_count;
	logic soft_reset;
	logic lba_start;
	logic lba_done;
	logic [27:0] lba;
	logic buf_clear;
	logic buf_push;
	logic [7:0] buf_push_byte;
	logic buf_pop;
	logic [15:0] buf_word;
	logic buf_empty;
	logic buf_full;

	ide_bus_sync ide_bus_sync_i (
		.clock(clock),
		.reset(reset),
		.cs_cmd_n(cs_cmd_n),
		.cs_ctl_n(cs_ctl_n),
		.read_n(read_n),
		.write_n(write_n),
		.address(address),
		.data_in(data_in),
		.access(access)
	);

	ide_task_file ide_task_file_i (
		.clock(clock),
		.reset(reset),
		.access(access),
		.status(status),
		.error(error),
		.buf_word(buf_word),
		.load_error(load_error),
		.task_addr(task_addr),
		.use_lba(use_lba),
		.sector_count(sector_count),
		.data_out(data_out),
		.soft_reset(soft_reset)
	);

	chs_to_lba #(
		.num_heads(num_heads),
		.sectors_per_track(sectors_per_track)
	) chs_to_lba_i (
		.clock(clock),
		.reset(reset),
		.start(lba_start),
		.chs(task_addr),
		.lba(lba),
		.done(lba_done)
	);

	sector_buffer sector_buffer_i (
		.clock(clock),
		.reset(reset),
		.clear(buf_clear),
		.push(buf_push),
		.push_byte(buf_push_byte),
		.pop(buf_pop),
		.head_word(buf_word),
		.empty(buf_empty),
		.full(buf_full)
	);

	ide_command_ctrl #(
		.read_credits(read_credits)
	) ide_command_ctrl_i (
		.clock(clock),
		.reset(reset),
		.access(access),
		.soft_reset(soft_reset),
		.use_lba(use_lba),
		.task_addr(task_addr),
		.sector_count(sector_count),
		.lba_done(lba_done),
		.lba(lba),
		.buf_empty(buf_empty),
		.buf_full(buf_full),
		.buf_head(buf_word[7:0]), // Next byte out of the buffer
		.cmd_credit(cmd_credit),
		.wr_credit(wr_credit),
		.rd_byte(rd_byte),
		.sector_done(sector_done),
		.sector_error(sector_error),
		.status(status),
		.error(error),
		.load_error(load_error),
		.lba_start(lba_start),
		.buf_clear(buf_clear),
		.buf_push(buf_push),
		.buf_push_byte(buf_push_byte),
		.buf_pop(buf_pop),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.wr_byte(wr_byte),
		.rd_credit(rd_credit)
	);

endmodule

//--- verif/storage_model.sv
// Block device model for the credit-based storage port
// Credits come back after random delays drawn from a fixed seed
// Reads return (lba + index) mod 256 and sector 999 reports an error
// Requests and write bytes are kept in req_log and wr_log
`timescale 1ns/1ns

module storage_model (
	input logic clock,
	input logic reset,
	input logic cmd_valid,
	input ide_pkg::blk_cmd_t cmd,
	input ide_pkg::blk_byte_t wr_byte,
	input logic rd_credit,
	output logic cmd_credit,
	output logic wr_credit,
	output ide_pkg::blk_byte_t rd_byte,
	output logic sector_done,
	output logic sector_error
);

	typedef enum logic [1:0] {m_idle, m_read, m_write} phase_e;

	ide_pkg::blk_cmd_t req_log [$];
	logic [7:0] wr_log [$];
	integer seed = 32'ha418_e398;
	phase_e phase;
	logic credit_owed; // Command credit not yet returned
	logic [9:0] grants_left;
	logic [9:0] index;
	logic [4:0] rd_held; // Read credits held by storage
	logic [27:0] cur_lba;
	logic [27:0] byte_sum;

	assign byte_sum = cur_lba + 28'(index);

	always @(posedge clock or posedge reset) begin
		if (reset) begin
			phase <= m_idle;
			credit_owed <= 1'b0;
			grants_left <= 10'd0;
			index <= 10'd0;
			rd_held <= 5'd0;
			cur_lba <= 28'd0;
			cmd_credit <= 1'b0;
			wr_credit <= 1'b0;
			rd_byte <= '0;
			sector_done <= 1'b0;
			sector_error <= 1'b0;
		end else begin
			cmd_credit <= 1'b0;
			wr_credit <= 1'b0;
			rd_byte <= '0;
			sector_done <= 1'b0;
			if (credit_owed && ($random(seed) & 3) == 0) begin
				cmd_credit <= 1'b1;
				credit_owed <= 1'b0;
			end
			case (phase)
				m_idle:
					if (cmd_valid) begin
						req_log.push_back(cmd);
						credit_owed <= 1'b1;
						cur_lba <= cmd.lba;
						index <= 10'd0;
						rd_held <= 5'd0;
						grants_left <= 10'd512; // One credit per byte of the sector
						phase <= cmd.write ? m_write : m_read;
					end
				m_write: begin
					if (grants_left != 10'd0 && ($random(seed) & 1) == 0) begin
						wr_credit <= 1'b1;
						grants_left <= grants_left - 10'd1;
					end
					if (wr_byte.valid) begin
						wr_log.push_back(wr_byte.data);
						index <= index + 10'd1;
					end
					if (index == 10'd512) begin
						sector_done <= 1'b1;
						sector_error <= cur_lba == 28'd999;
						phase <= m_idle;
					end
				end
				m_read:
					if (index == 10'd512) begin
						sector_done <= 1'b1;
						sector_error <= cur_lba == 28'd999;
						phase <= m_idle;
					end else if (rd_held != 5'd0 && ($random(seed) & 1) == 0) begin
						rd_byte <= '{valid: 1'b1, data: byte_sum[7:0]};
						index <= index + 10'd1;
						rd_held <= rd_held + 5'(rd_credit) - 5'd1;
					end else
						rd_held <= rd_held + 5'(rd_credit);
				default: phase <= m_idle;
			endcase
		end
	end

endmodule

//--- verif/tb_ide_block_bridge.sv
// Testbench for the IDE task-file bridge with a credit-based storage model
// Host accesses follow the strobe timing of the bus front end
// Inputs move 1 ns after the rising edge
// Geometry is 16 heads and 63 sectors per track
`timescale 1ns/1ns

module tb_ide_block_bridge;

	localparam int num_heads = 16;
	localparam int sectors_per_track = 63;
	localparam int read_credits = 8;
	localparam int poll_limit = 3000; // Status reads before a wait gives up

	logic clock;
	logic reset;
	logic cs_cmd_n;
	logic cs_ctl_n;
	logic read_n;
	logic write_n;
	logic [2:0] address;
	logic [15:0] data_in;
	logic [15:0] data_out;
	logic cmd_credit;
	logic wr_credit;
	ide_pkg::blk_byte_t rd_byte;
	logic sector_done;
	logic sector_error;
	logic cmd_valid;
	ide_pkg::blk_cmd_t cmd;
	ide_pkg::blk_byte_t wr_byte;
	logic rd_credit;
	integer seed = 32'ha418_e398;
	int failures = 0;
	int failures_at_start = 0;
	int tests_run = 0;
	int tests_failed = 0;

	ide_block_bridge #(
		.num_heads(num_heads),
		.sectors_per_track(sectors_per_track),
		.read_credits(read_credits)
	) ide_block_bridge_i (
		.clock(clock),
		.reset(reset),
		.cs_cmd_n(cs_cmd_n),
		.cs_ctl_n(cs_ctl_n),
		.read_n(read_n),
		.write_n(write_n),
		.address(address),
		.data_in(data_in),
		.data_out(data_out),
		.cmd_credit(cmd_credit),
		.wr_credit(wr_credit),
		.rd_byte(rd_byte),
		.sector_done(sector_done),
		.sector_error(sector_error),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.wr_byte(wr_byte),
		.rd_credit(rd_credit)
	);

	storage_model storage_model_i (
		.clock(clock),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.wr_byte(wr_byte),
		.rd_credit(rd_credit),
		.cmd_credit(cmd_credit),
		.wr_credit(wr_credit),
		.rd_byte(rd_byte),
		.sector_done(sector_done),
		.sector_error(sector_error)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic check(input logic ok, input string msg);
		assert (ok) else begin
			$display("FAILED at %0t: %s", $time, msg);
			failures++;
		end
	endtask

	// Credit rules of the storage port, sampled away from the active edge
	always @(negedge clock) begin
		if (!reset) begin
			check(storage_model_i.rd_held <= 5'(read_credits),
				$sformatf("storage holds %0d read credits, limit is %0d",
				storage_model_i.rd_held, read_credits));
			check(!(cmd_valid && storage_model_i.credit_owed),
				"storage request sent without a command credit");
		end
	end

	task automatic start_test();
		failures_at_start = failures;
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (failures == failures_at_start)
			$display("test %0d %s: ok", tests_run, name);
		else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, failures - failures_at_start);
		end
	endtask

	// Write strobe held 3 cycles and select released one cycle after it rises
	task automatic bus_write(input logic ctl, input logic [2:0] addr, input logic [15:0] value);
		@(posedge clock);
		#1;
		cs_cmd_n = ctl;
		cs_ctl_n = !ctl;
		address = addr;
		data_in = value;
		write_n = 1'b0;
		repeat (3) @(posedge clock);
		#1 write_n = 1'b1;
		@(posedge clock);
		#1;
		cs_cmd_n = 1'b1;
		cs_ctl_n = 1'b1;
		repeat (3) @(posedge clock);
	endtask

	task automatic bus_read(input logic [2:0] addr, output logic [15:0] value);
		@(posedge clock);
		#1;
		cs_cmd_n = 1'b0;
		address = addr;
		read_n = 1'b0;
		repeat (4) @(posedge clock);
		#1;
		value = data_out; // Sampled just before the strobe rises
		read_n = 1'b1;
		@(posedge clock);
		#1 cs_cmd_n = 1'b1;
		repeat (3) @(posedge clock);
	endtask

	task automatic write_reg(input logic [2:0] addr, input logic [7:0] value);
		bus_write(1'b0, addr, {8'h00, value});
	endtask

	task automatic read_reg(input logic [2:0] addr, output logic [7:0] value);
		logic [15:0] word;
		bus_read(addr, word);
		value = word[7:0];
	endtask

	task automatic expect_reg(input logic [2:0] addr, input logic [7:0] expected,
		input string name);
		logic [7:0] value;
		read_reg(addr, value);
		check(value == expected, $sformatf("%s read %h, expected %h", name, value, expected));
	endtask

	task automatic wait_not_busy(input string what, output logic [7:0] stat);
		int polls;
		logic [15:0] value;
		polls = 0;
		bus_read(3'd7, value);
		while (value[7] && polls < poll_limit) begin
			bus_read(3'd7, value);
			polls++;
		end
		if (value[7]) begin
			$display("Timeout: BSY still set after %0d status reads while waiting for %s",
				polls, what);
			failures++;
		end
		stat = value[7:0];
	endtask

	task automatic load_lba(input logic [27:0] lba, input logic [7:0] count);
		write_reg(3'd2, count);
		write_reg(3'd3, lba[7:0]);
		write_reg(3'd4, lba[15:8]);
		write_reg(3'd5, lba[23:16]);
		write_reg(3'd6, {4'hE, lba[27:24]}); // LBA bit set
	endtask

	// Expected LBA from the CHS rule of the fixed geometry
	function automatic logic [27:0] chs_lba(input int cylinder, input int head, input int sector);
		return 28'((cylinder * num_heads + head) * sectors_per_track + sector - 1);
	endfunction

	function automatic logic [7:0] storage_byte(input logic [27:0] lba, input int index);
		logic [27:0] sum;
		sum = lba + 28'(index);
		return sum[7:0];
	endfunction

	task automatic reset_readback();
		logic [7:0] stat;
		start_test();
		wait_not_busy("ready after reset", stat);
		check(stat == 8'h40, $sformatf("status %h after reset, expected 40", stat));
		write_reg(3'd2, 8'h12);
		write_reg(3'd3, 8'h34);
		write_reg(3'd4, 8'h56);
		write_reg(3'd5, 8'h78);
		write_reg(3'd6, 8'hF5); // LBA and drive bits set, head 5
		expect_reg(3'd2, 8'h12, "sector count");
		expect_reg(3'd3, 8'h34, "sector number");
		expect_reg(3'd4, 8'h56, "cylinder low");
		expect_reg(3'd5, 8'h78, "cylinder high");
		expect_reg(3'd6, 8'hF5, "device/head");
		report_test("reset and readback");
	endtask

	task automatic unsupported_command();
		logic [7:0] stat;
		start_test();
		write_reg(3'd7, 8'hEC);
		wait_not_busy("abort of command EC", stat);
		check(stat == 8'h41, $sformatf("status %h after command EC, expected 41", stat));
		expect_reg(3'd1, 8'h04, "error register");
		report_test("unsupported command");
	endtask

	task automatic lba_write();
		logic [27:0] lba;
		logic [7:0] stat;
		logic [15:0] word;
		logic [15:0] words [$];
		int req_base;
		int byte_base;
		start_test();
		lba = 28'($random(seed));
		if (lba == 28'd999)
			lba = 28'd1000; // Keep clear of the error sector
		req_base = storage_model_i.req_log.size();
		byte_base = storage_model_i.wr_log.size();
		load_lba(lba, 8'd1);
		write_reg(3'd7, 8'h30);
		wait_not_busy("write data request", stat);
		check(stat == 8'h48, $sformatf("status %h before write data, expected 48", stat));
		for (int i = 0; i < 256; i++) begin
			word = 16'($random(seed));
			words.push_back(word);
			bus_write(1'b0, 3'd0, word);
		end
		wait_not_busy("write completion", stat);
		check(stat == 8'h40, $sformatf("status %h after write, expected 40", stat));
		check(storage_model_i.req_log.size() == req_base + 1, "expected one storage request");
		check(storage_model_i.wr_log.size() == byte_base + 512, "expected 512 bytes at storage");
		if (storage_model_i.req_log.size() == req_base + 1)
			check(storage_model_i.req_log[req_base] == {lba, 1'b1},
				$sformatf("write request %h, expected lba %h",
				storage_model_i.req_log[req_base], lba));
		if (storage_model_i.wr_log.size() == byte_base + 512) begin
			for (int i = 0; i < 256; i++) begin
				check(storage_model_i.wr_log[byte_base + 2 * i] == words[i][7:0],
					$sformatf("low byte of word %0d differs at storage", i));
				check(storage_model_i.wr_log[byte_base + 2 * i + 1] == words[i][15:8],
					$sformatf("high byte of word %0d differs at storage", i));
			end
		end
		report_test("lba write");
	endtask

	task automatic chs_read();
		logic [27:0] lba;
		logic [7:0] stat;
		logic [15:0] word;
		logic [15:0] expected;
		int req_base;
		start_test();
		lba = chs_lba(300, 3, 7);
		req_base = storage_model_i.req_log.size();
		write_reg(3'd2, 8'd2);
		write_reg(3'd3, 8'd7);
		write_reg(3'd4, 8'h2C); // Cylinder 300
		write_reg(3'd5, 8'h01);
		write_reg(3'd6, 8'hA3);
		write_reg(3'd7, 8'h20);
		for (int s = 0; s < 2; s++) begin
			wait_not_busy("read data ready", stat);
			check(stat == 8'h48, $sformatf("status %h before sector %0d, expected 48", stat, s));
			for (int i = 0; i < 256; i++) begin
				bus_read(3'd0, word);
				expected = {storage_byte(lba + 28'(s), 2 * i + 1),
					storage_byte(lba + 28'(s), 2 * i)};
				check(word == expected,
					$sformatf("sector %0d word %0d read %h, expected %h", s, i, word, expected));
			end
		end
		wait_not_busy("read completion", stat);
		check(stat == 8'h40, $sformatf("status %h after read, expected 40", stat));
		check(storage_model_i.req_log.size() == req_base + 2, "expected two storage requests");
		if (storage_model_i.req_log.size() == req_base + 2) begin
			check(storage_model_i.req_log[req_base] == {lba, 1'b0}, "first read request LBA wrong");
			check(storage_model_i.req_log[req_base + 1] == {lba + 28'd1, 1'b0},
				"second read request LBA wrong");
		end
		report_test("chs read two sectors");
	endtask

	task automatic storage_error();
		logic [7:0] stat;
		start_test();
		load_lba(28'd999, 8'd1);
		write_reg(3'd7, 8'h20);
		wait_not_busy("failed read at LBA 999", stat);
		check(stat == 8'h41, $sformatf("status %h after storage error, expected 41", stat));
		expect_reg(3'd1, 8'h40, "error register");
		report_test("storage error");
	endtask

	task automatic software_reset();
		logic [7:0] stat;
		start_test();
		write_reg(3'd2, 8'h09);
		write_reg(3'd3, 8'h22);
		write_reg(3'd4, 8'h11);
		write_reg(3'd5, 8'h33);
		bus_write(1'b1, 3'd6, 16'h0004); // SRST set
		bus_write(1'b1, 3'd6, 16'h0000);
		wait_not_busy("ready after software reset", stat);
		check(stat == 8'h40, $sformatf("status %h after software reset, expected 40", stat));
		expect_reg(3'd2, 8'h01, "sector count");
		expect_reg(3'd3, 8'h01, "sector number");
		expect_reg(3'd4, 8'h00, "cylinder low");
		expect_reg(3'd5, 8'h00, "cylinder high");
		report_test("software reset");
	endtask

	initial begin
		reset = 1'b1;
		cs_cmd_n = 1'b1;
		cs_ctl_n = 1'b1;
		read_n = 1'b1;
		write_n = 1'b1;
		address = 3'd0;
		data_in = 16'h0000;
		repeat (5) @(posedge clock);
		#1 reset = 1'b0;
		reset_readback();
		unsupported_command();
		lba_write();
		chs_read();
		storage_error();
		software_reset();
		$display("%0d tests run, %0d passed, %0d failed, %0d check failures",
			tests_run, tests_run - tests_failed, tests_failed, failures);
		if (failures == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- sources.f
source/ide_pkg.sv
source/ide_bus_sync.sv
source/ide_task_file.sv
source/chs_to_lba.sv
source/sector_buffer.sv
source/ide_command_ctrl.sv
source/ide_block_bridge.sv
verif/storage_model.sv
verif/tb_ide_block_bridge.sv

//--- run.sh
#!/bin/sh
# Build and run the IDE bridge testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
	--top-module tb_ide_block_bridge -Mdir obj_dir -f sources.f
./obj_dir/Vtb_ide_block_bridge | tee sim.log
if grep -q ">>> FAIL" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
